// ==== verilog/sprite_pkg.sv ====
// shared sprite types and list decode, Terra Cresta layout only
// 512 tiles, pen 0 transparent, no palette bank lookup

package sprite_pkg;

    // ========================================
    // screen and list geometry
    // ========================================
    localparam int SPRITE_COUNT     = 64;
    localparam int BYTES_PER_SPRITE = 4;
    localparam int SPRITE_SIZE      = 16;
    localparam int LINE_WIDTH       = 256;
    localparam int TRANSPARENT_PEN  = 0;
    localparam int Y_BASE           = 240;
    localparam int X_BIAS           = 128;

    // one decoded list entry, 32 bits
    typedef struct packed {
        logic [8:0] tile;
        logic [8:0] x_pos;
        logic [7:0] y_pos;
        logic [3:0] colour;
        logic       flip_x;
        logic       flip_y;
    } sprite_attr_t;

    // line buffer entry
    typedef struct packed {
        logic [3:0] colour;
        logic [3:0] pen;
    } sprite_pixel_t;

    typedef struct packed {
        logic        wr;
        logic [15:0] addr;
        logic [7:0]  data;
    } rom_load_t;

    typedef struct packed {
        logic       wr;
        logic [7:0] addr;
        logic [7:0] data;
    } ram_write_t;

    // four list bytes to attributes
    function automatic sprite_attr_t decode_entry(
        input logic [7:0] y_byte,
        input logic [7:0] tile_byte,
        input logic [7:0] attr_byte,
        input logic [7:0] x_byte
    );
        sprite_attr_t s;
        s.y_pos  = 8'(Y_BASE) - y_byte;
        s.tile   = {attr_byte[1], tile_byte};
        s.flip_x = attr_byte[2];
        s.flip_y = attr_byte[3];
        s.colour = attr_byte[7:4];
        // attr bit 0 is x bit 8, wraps modulo 512
        s.x_pos  = {attr_byte[0], x_byte} - 9'(X_BIAS);
        return s;
    endfunction

endpackage

// ==== verilog/sprite_dp_ram.sv ====
// simple dual port RAM, one write port and one registered read port
// no reset, contents undefined until written
`timescale 1ns/1ns

module sprite_dp_ram #(
    parameter int  DEPTH     = 256,
    parameter type payload_t = logic [7:0]
) (
    input  logic                     clk_sys,
    input  logic                     wr,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk_sys) begin
        if (wr) begin
            mem[wr_addr] <= wr_data;
        end
        // read data one clock after address
        rd_data <= mem[rd_addr];
    end

    // writes must stay inside the array
    a_wr_in_range: assert property (
        @(posedge clk_sys) wr |-> (int'(wr_addr) < DEPTH)
    );

endmodule

// ==== verilog/sprite_list_copier.sv ====
// copies the 64 entry list on each vblank rise, 7 clocks per sprite
// CPU writes are not blocked while the copy runs
`timescale 1ns/1ns

module sprite_list_copier (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic                     vblank,
    output logic [7:0]               list_addr,
    input  logic [7:0]               list_data,
    output logic                     buf_wr,
    output logic [5:0]               buf_addr,
    output sprite_pkg::sprite_attr_t buf_data,
    output logic                     copy_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_RUN,
        S_DONE
    } state_t;

    // phase 0..3 address bytes, 1..4 capture, 5 decode, 6 write
    localparam logic [2:0] WRITE_PHASE = 3'(sprite_pkg::BYTES_PER_SPRITE + 1);
    localparam logic [2:0] LAST_PHASE  = 3'(sprite_pkg::BYTES_PER_SPRITE + 2);

    state_t      state;
    logic        vblank_q;
    logic        vblank_rise;
    logic [5:0]  sprite_idx;
    logic [2:0]  phase;
    logic [31:0] entry_bytes;
    logic        last_sprite;
    logic        capture;

    assign vblank_rise = vblank && !vblank_q;
    assign last_sprite = (sprite_idx == 6'(sprite_pkg::SPRITE_COUNT - 1));
    assign capture     = (state == S_RUN) && (phase >= 3'd1) &&
                         (phase <= 3'(sprite_pkg::BYTES_PER_SPRITE));

    assign list_addr = {sprite_idx, phase[1:0]};
    assign buf_addr  = sprite_idx;
    assign copy_busy = (state != S_IDLE);

    // ========================================
    // control
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vblank_q   <= 1'b0;
            state      <= S_IDLE;
            buf_wr     <= 1'b0;
            sprite_idx <= '0;
            phase      <= '0;
        end else begin
            vblank_q <= vblank;
            buf_wr   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (vblank_rise) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    sprite_idx <= '0;
                    phase      <= '0;
                    state      <= S_RUN;
                end
                S_RUN: begin
                    if (phase == WRITE_PHASE) begin
                        buf_wr <= 1'b1;
                    end
                    if (phase == LAST_PHASE) begin
                        phase <= '0;
                        if (last_sprite) begin
                            state <= S_DONE;
                        end else begin
                            sprite_idx <= sprite_idx + 6'd1;
                        end
                    end else begin
                        phase <= phase + 3'd1;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // byte capture and decode
    // ========================================
    always_ff @(posedge clk_sys) begin
        // bytes shift in from the top, byte 0 ends up lowest
        if (capture) begin
            entry_bytes <= {list_data, entry_bytes[31:8]};
        end
        if (state == S_RUN && phase == WRITE_PHASE) begin
            buf_data <= sprite_pkg::decode_entry(entry_bytes[7:0], entry_bytes[15:8],
                                                 entry_bytes[23:16], entry_bytes[31:24]);
        end
    end

    // buffer writes only happen inside a copy
    a_wr_during_copy: assert property (
        @(posedge clk_sys) disable iff (reset) buf_wr |-> copy_busy
    );

endmodule

// ==== verilog/sprite_line_renderer.sv ====
// renders line vcount+1 into the line buffer during hblank (hcount >= 256)
// worst case 256 + 64*20 clocks, readout one clock behind hcount
`timescale 1ns/1ns

module sprite_line_renderer #(
    parameter int GFX_ADDR_W = 16
) (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic [8:0]                hcount,
    input  logic [7:0]                vcount,
    output logic [5:0]                buf_addr,
    input  sprite_pkg::sprite_attr_t  buf_data,
    output logic [GFX_ADDR_W-1:0]     gfx_addr,
    input  logic [7:0]                gfx_data,
    output sprite_pkg::sprite_pixel_t sprite_pixel,
    output logic                      draw_busy
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_CLEAR,
        S_LOAD,
        S_CHECK,
        S_FETCH
    } state_t;

    state_t                    state;
    logic [8:0]                hcount_q;
    logic                      render_start;
    logic [7:0]                target_line;
    logic [7:0]                clear_x;
    logic [5:0]                sprite_idx;
    logic                      last_sprite;
    logic [4:0]                fetch_cnt;
    sprite_pkg::sprite_attr_t  attr;
    logic [3:0]                row;
    logic [8:0]                row_diff;
    logic                      hit;
    logic [3:0]                flip_col;
    logic                      visible_q;

    // fetch pipeline, s1 holds the issued address, s2 meets the ROM data
    logic                      s1_valid;
    logic [3:0]                s1_ofs;
    logic                      s1_hi;
    logic                      s2_valid;
    logic [3:0]                s2_ofs;
    logic                      s2_hi;
    logic [3:0]                pen;
    logic [9:0]                px;

    logic                      lb_wr;
    logic [7:0]                lb_wr_addr;
    sprite_pkg::sprite_pixel_t lb_wr_data;
    sprite_pkg::sprite_pixel_t lb_rd_data;

    assign render_start = (state == S_IDLE) &&
                          (hcount == 9'(sprite_pkg::LINE_WIDTH)) && (hcount_q != hcount);
    assign last_sprite  = (sprite_idx == 6'(sprite_pkg::SPRITE_COUNT - 1));
    assign buf_addr     = sprite_idx;
    assign draw_busy    = (state != S_IDLE);

    // no wrap at the bottom of the screen
    assign row_diff = {1'b0, target_line} - {1'b0, buf_data.y_pos};
    assign hit      = !row_diff[8] && (row_diff[7:0] < 8'(sprite_pkg::SPRITE_SIZE));

    assign flip_col = attr.flip_x ? 4'd15 - fetch_cnt[3:0] : fetch_cnt[3:0];

    assign pen = s2_hi ? gfx_data[7:4] : gfx_data[3:0];
    // 10 bits so sprites right of 511 never wrap to the left edge
    assign px  = {1'b0, attr.x_pos} + {6'd0, s2_ofs};

    // ========================================
    // control
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state      <= S_IDLE;
            hcount_q   <= '0;
            clear_x    <= '0;
            sprite_idx <= '0;
            fetch_cnt  <= '0;
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            visible_q  <= 1'b0;
        end else begin
            hcount_q  <= hcount;
            visible_q <= (hcount < 9'(sprite_pkg::LINE_WIDTH));
            s1_valid  <= (state == S_FETCH) && (fetch_cnt < 5'(sprite_pkg::SPRITE_SIZE));
            s2_valid  <= s1_valid;
            case (state)
                S_IDLE: begin
                    if (render_start) begin
                        clear_x <= '0;
                        state   <= S_CLEAR;
                    end
                end
                S_CLEAR: begin
                    if (clear_x == 8'(sprite_pkg::LINE_WIDTH - 1)) begin
                        sprite_idx <= '0;
                        state      <= S_LOAD;
                    end else begin
                        clear_x <= clear_x + 8'd1;
                    end
                end
                // sprite buffer read in flight
                S_LOAD: begin
                    state <= S_CHECK;
                end
                S_CHECK: begin
                    if (hit) begin
                        fetch_cnt <= '0;
                        state     <= S_FETCH;
                    end else if (last_sprite) begin
                        state <= S_IDLE;
                    end else begin
                        sprite_idx <= sprite_idx + 6'd1;
                        state      <= S_LOAD;
                    end
                end
                // 16 issue cycles then 2 to drain the pipeline
                S_FETCH: begin
                    if (fetch_cnt == 5'(sprite_pkg::SPRITE_SIZE + 1)) begin
                        if (last_sprite) begin
                            state <= S_IDLE;
                        end else begin
                            sprite_idx <= sprite_idx + 6'd1;
                            state      <= S_LOAD;
                        end
                    end else begin
                        fetch_cnt <= fetch_cnt + 5'd1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ========================================
    // datapath
    // ========================================
    always_ff @(posedge clk_sys) begin
        if (render_start) begin
            target_line <= vcount + 8'd1;
        end
        if (state == S_CHECK) begin
            attr <= buf_data;
            row  <= buf_data.flip_y ? 4'd15 - row_diff[3:0] : row_diff[3:0];
        end
        // original board layout, narrowed to 16 bits
        gfx_addr <= GFX_ADDR_W'({flip_col[1], attr.tile, row, flip_col[3:2]});
        s1_ofs   <= fetch_cnt[3:0];
        s1_hi    <= flip_col[0];
        s2_ofs   <= s1_ofs;
        s2_hi    <= s1_hi;
    end

    // write port, clear pass or opaque sprite pixels
    always_comb begin
        lb_wr_data        = '0;
        lb_wr_data.colour = attr.colour;
        lb_wr_data.pen    = pen;
        lb_wr_addr        = px[7:0];
        lb_wr             = s2_valid && (pen != 4'(sprite_pkg::TRANSPARENT_PEN)) &&
                            (px < 10'(sprite_pkg::LINE_WIDTH));
        if (state == S_CLEAR) begin
            lb_wr_data = '0;
            lb_wr_addr = clear_x;
            lb_wr      = 1'b1;
        end
    end

    sprite_dp_ram #(
        .DEPTH     (sprite_pkg::LINE_WIDTH),
        .payload_t (sprite_pkg::sprite_pixel_t)
    ) line_buffer (
        .clk_sys (clk_sys),
        .wr      (lb_wr),
        .wr_addr (lb_wr_addr),
        .wr_data (lb_wr_data),
        .rd_addr (hcount[7:0]),
        .rd_data (lb_rd_data)
    );

    assign sprite_pixel = visible_q ? lb_rd_data : '0;

    // render must finish inside hblank
    a_done_by_line_start: assert property (
        @(posedge clk_sys) disable iff (reset) (hcount == 9'd0) |-> !draw_busy
    );

endmodule

// ==== verilog/sprite_engine.sv ====
// sprite subsystem top, timing comes in as vblank, hcount and vcount
// graphics ROM is 2**GFX_ADDR_W bytes, loaded through rom_load
`timescale 1ns/1ns

module sprite_engine #(
    parameter int GFX_ADDR_W = 16
) (
    input  logic                      clk_sys,
    input  logic                      reset,
    input  logic                      vblank,
    input  logic [8:0]                hcount,
    input  logic [7:0]                vcount,
    input  sprite_pkg::ram_write_t    cpu_write,
    input  sprite_pkg::rom_load_t     rom_load,
    output sprite_pkg::sprite_pixel_t sprite_pixel,
    output logic                      copy_busy,
    output logic                      draw_busy
);

    logic [7:0]               list_addr;
    logic [7:0]               list_data;
    logic                     sbuf_wr;
    logic [5:0]               sbuf_wr_addr;
    sprite_pkg::sprite_attr_t sbuf_wr_data;
    logic [5:0]               sbuf_rd_addr;
    sprite_pkg::sprite_attr_t sbuf_rd_data;
    logic [GFX_ADDR_W-1:0]    gfx_addr;
    logic [7:0]               gfx_data;

    // shared list written by the CPU
    sprite_dp_ram #(
        .DEPTH     (sprite_pkg::SPRITE_COUNT * sprite_pkg::BYTES_PER_SPRITE),
        .payload_t (logic [7:0])
    ) list_ram (
        .clk_sys (clk_sys),
        .wr      (cpu_write.wr),
        .wr_addr (cpu_write.addr),
        .wr_data (cpu_write.data),
        .rd_addr (list_addr),
        .rd_data (list_data)
    );

    // decoded attributes, one word per sprite
    sprite_dp_ram #(
        .DEPTH     (sprite_pkg::SPRITE_COUNT),
        .payload_t (sprite_pkg::sprite_attr_t)
    ) sprite_buffer (
        .clk_sys (clk_sys),
        .wr      (sbuf_wr),
        .wr_addr (sbuf_wr_addr),
        .wr_data (sbuf_wr_data),
        .rd_addr (sbuf_rd_addr),
        .rd_data (sbuf_rd_data)
    );

    sprite_dp_ram #(
        .DEPTH     (1 << GFX_ADDR_W),
        .payload_t (logic [7:0])
    ) gfx_rom (
        .clk_sys (clk_sys),
        .wr      (rom_load.wr),
        .wr_addr (rom_load.addr[GFX_ADDR_W-1:0]),
        .wr_data (rom_load.data),
        .rd_addr (gfx_addr),
        .rd_data (gfx_data)
    );

    sprite_list_copier sprite_list_copier_inst (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .vblank    (vblank),
        .list_addr (list_addr),
        .list_data (list_data),
        .buf_wr    (sbuf_wr),
        .buf_addr  (sbuf_wr_addr),
        .buf_data  (sbuf_wr_data),
        .copy_busy (copy_busy)
    );

    sprite_line_renderer #(
        .GFX_ADDR_W (GFX_ADDR_W)
    ) sprite_line_renderer_inst (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .hcount       (hcount),
        .vcount       (vcount),
        .buf_addr     (sbuf_rd_addr),
        .buf_data     (sbuf_rd_data),
        .gfx_addr     (gfx_addr),
        .gfx_data     (gfx_data),
        .sprite_pixel (sprite_pixel),
        .draw_busy    (draw_busy)
    );

endmodule

// ==== test/sprite_engine_tb.sv ====
// line by line compare of sprite_pixel against a reference model of the decode rules
// graphics ROM filled from a 16 bit Galois LFSR with seed 31 and one step per bit
`timescale 1ns/1ns

module sprite_engine_tb;

    localparam int GFX_ADDR_W = 16;
    localparam int ROM_BYTES  = 1 << GFX_ADDR_W;
    localparam int HOLD_CLKS  = 16;
    localparam int LINE_CLKS  = 384 * HOLD_CLKS;
    localparam int COPY_CLKS  = 64 * 7 + 2;
    // every scan runs one unchecked line before its first checked line
    localparam int LINES_USED = 5 + 21 + 21 + 21 + 27 + 19;
    localparam int COPIES     = 6;
    localparam int TIMEOUT_NS = (LINES_USED * LINE_CLKS + ROM_BYTES +
                                 COPIES * (256 + COPY_CLKS + 8)) * 8 + 200_000;

    logic                      clk_sys;
    logic                      reset;
    logic                      vblank;
    logic [8:0]                hcount;
    logic [7:0]                vcount;
    sprite_pkg::ram_write_t    cpu_write;
    sprite_pkg::rom_load_t     rom_load;
    sprite_pkg::sprite_pixel_t sprite_pixel;
    logic                      copy_busy;
    logic                      draw_busy;

    logic [7:0]  list_mem [256];
    logic [7:0]  rom_copy [ROM_BYTES];
    logic [7:0]  exp_line [256];
    logic [15:0] lfsr_state;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_start_errors;

    sprite_engine #(
        .GFX_ADDR_W (GFX_ADDR_W)
    ) sprite_engine_inst (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .vblank       (vblank),
        .hcount       (hcount),
        .vcount       (vcount),
        .cpu_write    (cpu_write),
        .rom_load     (rom_load),
        .sprite_pixel (sprite_pixel),
        .copy_busy    (copy_busy),
        .draw_busy    (draw_busy)
    );

    initial begin
        clk_sys = 1'b0;
        forever #4 clk_sys = ~clk_sys;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    // ========================================
    // random source and reference model
    // ========================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected pixels of one line with later list entries drawn on top
    task automatic build_expected(input int line);
        logic [7:0]  y_byte, tile_byte, attr_byte, x_byte, g;
        logic [15:0] addr;
        logic [3:0]  p;
        int          y, x, tile, rd, row, fc, px;
        for (int i = 0; i < 256; i++) begin
            exp_line[i] = 8'h00;
        end
        for (int s = 0; s < 64; s++) begin
            y_byte    = list_mem[4 * s];
            tile_byte = list_mem[4 * s + 1];
            attr_byte = list_mem[4 * s + 2];
            x_byte    = list_mem[4 * s + 3];
            y    = (240 - int'(y_byte)) & 255;
            tile = int'(attr_byte[1]) * 256 + int'(tile_byte);
            x    = (int'(attr_byte[0]) * 256 + int'(x_byte) - 128) & 511;
            rd   = line - y;
            if (rd >= 0 && rd < 16) begin
                row = attr_byte[3] ? 15 - rd : rd;
                for (int ofs = 0; ofs < 16; ofs++) begin
                    fc   = attr_byte[2] ? 15 - ofs : ofs;
                    addr = 16'((((fc >> 1) & 1) << 15) | (tile << 6) | (row << 2) | (fc >> 2));
                    g    = rom_copy[addr];
                    p    = ((fc & 1) != 0) ? g[7:4] : g[3:0];
                    px   = x + ofs;
                    if (px < 256 && p != 4'd0) begin
                        exp_line[px] = {attr_byte[7:4], p};
                    end
                end
            end
        end
    endtask

    // ========================================
    // stimulus
    // ========================================
    task automatic fill_rom();
        logic [7:0] b;
        for (int a = 0; a < ROM_BYTES; a++) begin
            take_random_byte(b);
            rom_copy[a] = b;
            @(posedge clk_sys);
            rom_load.wr   <= 1'b1;
            rom_load.addr <= 16'(a);
            rom_load.data <= b;
        end
        @(posedge clk_sys);
        rom_load.wr <= 1'b0;
    endtask

    task automatic clear_list();
        for (int a = 0; a < 256; a++) begin
            list_mem[a] = 8'h00;
        end
    endtask

    task automatic set_sprite(input int idx, input logic [7:0] y_byte,
                              input logic [7:0] tile_byte, input logic [7:0] attr_byte,
                              input logic [7:0] x_byte);
        list_mem[4 * idx]     = y_byte;
        list_mem[4 * idx + 1] = tile_byte;
        list_mem[4 * idx + 2] = attr_byte;
        list_mem[4 * idx + 3] = x_byte;
    endtask

    // CPU writes the whole list and a vblank rise then copies it
    task automatic copy_list();
        int wait_cnt;
        int cycles;
        for (int a = 0; a < 256; a++) begin
            @(posedge clk_sys);
            cpu_write.wr   <= 1'b1;
            cpu_write.addr <= 8'(a);
            cpu_write.data <= list_mem[a];
        end
        @(posedge clk_sys);
        cpu_write.wr <= 1'b0;
        vblank       <= 1'b1;
        wait_cnt = 0;
        while (!copy_busy && wait_cnt < 16) begin
            @(negedge clk_sys);
            wait_cnt++;
        end
        cycles = 0;
        while (copy_busy && cycles < 4 * COPY_CLKS) begin
            cycles++;
            @(negedge clk_sys);
        end
        a_copy_started: assert (wait_cnt < 16) else begin
            errors++;
            $display("list copy never started after the vblank rise");
        end
        a_copy_length: assert (wait_cnt >= 16 || cycles == COPY_CLKS) else begin
            errors++;
            $display("FAIL %0t: list copy busy for %0d clocks, expected %0d",
                     $time, cycles, COPY_CLKS);
        end
        @(posedge clk_sys);
        vblank <= 1'b0;
    endtask

    // one full line of hcount with readout checked while check is set
    task automatic run_line(input int v, input bit check);
        logic [7:0] got;
        logic [7:0] expected;
        for (int h = 0; h < 384; h++) begin
            @(posedge clk_sys);
            hcount <= 9'(h);
            if (h == 0) begin
                vcount <= 8'(v);
            end
            repeat (2) @(negedge clk_sys);
            if (h == 0) begin
                a_idle_at_line_start: assert (!draw_busy) else begin
                    errors++;
                    $display("line render still busy at the start of line %0d", v);
                end
            end
            if (h == 256) begin
                a_render_started: assert (draw_busy) else begin
                    errors++;
                    $display("FAIL %0t: draw_busy low after hcount reached 256 on line %0d",
                             $time, v);
                end
            end
            if (check) begin
                got      = sprite_pixel;
                expected = (h < 256) ? exp_line[h] : 8'h00;
                checks++;
                a_pixel: assert (got == expected) else begin
                    errors++;
                    $display("FAIL %0t: line %0d x %0d pixel %02h, expected %02h",
                             $time, v, h, got, expected);
                end
            end
            repeat (HOLD_CLKS - 2) @(posedge clk_sys);
        end
    endtask

    // line first-1 renders line first and runs unchecked
    task automatic scan_lines(input int first, input int count);
        int v;
        for (int n = 0; n <= count; n++) begin
            v = (first - 1 + n) & 255;
            if (n > 0) begin
                build_expected(v);
            end
            run_line(v, n > 0);
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        reset      = 1'b1;
        vblank     = 1'b0;
        hcount     = 9'd300;
        vcount     = 8'd0;
        cpu_write  = '0;
        rom_load   = '0;
        lfsr_state = 16'd31;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk_sys);
        reset <= 1'b0;
        @(negedge clk_sys);

        begin_test();
        a_reset_state: assert (!copy_busy && !draw_busy && sprite_pixel == '0) else begin
            errors++;
            $display("FAIL %0t: outputs not zero after reset", $time);
        end
        end_test("reset");

        fill_rom();

        // all zero bytes put every sprite at x 384
        begin_test();
        clear_list();
        copy_list();
        scan_lines(238, 4);
        end_test("empty list");

        // y 100, x 60, tile 0x123, colour 7
        begin_test();
        set_sprite(5, 8'd140, 8'h23, 8'h72, 8'd188);
        copy_list();
        scan_lines(98, 20);
        end_test("single sprite");

        begin_test();
        set_sprite(5, 8'd140, 8'h23, 8'h76, 8'd188);
        copy_list();
        scan_lines(98, 20);
        end_test("flip x");

        begin_test();
        set_sprite(5, 8'd140, 8'h23, 8'h7A, 8'd188);
        copy_list();
        scan_lines(98, 20);
        end_test("flip y");

        // sprite 20 overlaps sprite 10 by 10 columns and 10 rows
        begin_test();
        clear_list();
        set_sprite(10, 8'd190, 8'h40, 8'h20, 8'd228);
        set_sprite(20, 8'd184, 8'h41, 8'h90, 8'd234);
        copy_list();
        scan_lines(48, 26);
        end_test("overlap");

        // x 256 stays hidden and x 248 shows 8 columns
        begin_test();
        clear_list();
        set_sprite(3, 8'd90, 8'h10, 8'h31, 8'h80);
        set_sprite(4, 8'd90, 8'h11, 8'h51, 8'h78);
        copy_list();
        scan_lines(148, 18);
        end_test("horizontal range");

        $display("tests run %0d, tests failed %0d, pixel checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/sprite_pkg.sv
verilog/sprite_dp_ram.sv
verilog/sprite_list_copier.sv
verilog/sprite_line_renderer.sv
verilog/sprite_engine.sv
test/sprite_engine_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module sprite_engine_tb \
    -f sources.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
    exit 0
fi
echo "simulation reported failures"
exit 1
